/* verilog/cache_geom_pkg.sv */
package cache_geom_pkg;

    // ----------------------------------------------------------------------
    // pixel and address geometry
    // ----------------------------------------------------------------------

    localparam int ADDR_W   = 8;
    localparam int BLK_SIZE = 2;
    localparam int BLK_PIX  = 1 << (2 * BLK_SIZE);
    localparam int PIX_W    = 8;

    // block coordinate and in-block offset widths
    localparam int BLK_W    = ADDR_W - BLK_SIZE;
    localparam int OFS_W    = 2 * BLK_SIZE;

    // ----------------------------------------------------------------------
    // packed types
    // ----------------------------------------------------------------------

    typedef struct packed {
        logic [ADDR_W-1:0] y;
        logic [ADDR_W-1:0] x;
    } coord_t;

    typedef struct packed {
        logic [BLK_W-1:0] y;
        logic [BLK_W-1:0] x;
    } blk_addr_t;

    // offset is raster order inside the block, y then x
    typedef struct packed {
        blk_addr_t        blk;
        logic [OFS_W-1:0] ofs;
        logic             miss;
    } pix_req_t;

    // low BLK_SIZE bits of both coordinates are zero
    typedef coord_t fetch_t;

endpackage

/* verilog/cache_ctrl_pkg.sv */
package cache_ctrl_pkg;

    // ----------------------------------------------------------------------
    // tag lookup states
    // ----------------------------------------------------------------------

    typedef enum logic {
        CLEARING,
        LOOKUP
    } decode_state_e;

    // ----------------------------------------------------------------------
    // result queue states
    // ----------------------------------------------------------------------

    // head entry is examined, refilled if needed, then answered
    typedef enum logic [1:0] {
        HEAD,
        FILL,
        RESPOND
    } result_state_e;

endpackage

/* verilog/tag_decode.sv */
module tag_decode #(
    parameter int TAG_ADDR_W = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     clear_start,
    output logic                     clear_busy,
    input  cache_geom_pkg::coord_t   s_araddr,
    input  logic                     s_arvalid,
    output logic                     s_arready,
    output logic                     status_hit,
    output logic                     status_miss,
    output cache_geom_pkg::pix_req_t req,
    output logic                     req_valid,
    input  logic                     req_ready,
    output cache_geom_pkg::fetch_t   fetch,
    output logic                     fetch_valid,
    input  logic                     fetch_ready
);

    localparam int TAG_NUM = 1 << TAG_ADDR_W;
    localparam int HALF_W  = TAG_ADDR_W / 2;
    localparam int BLK_W   = cache_geom_pkg::BLK_W;
    localparam int TAG_W   = 2 * (BLK_W - HALF_W);
    localparam int LO      = cache_geom_pkg::BLK_SIZE;
    localparam int HI      = cache_geom_pkg::ADDR_W - 1;

    cache_ctrl_pkg::decode_state_e state;
    logic [TAG_ADDR_W-1:0]         clear_idx;
    logic [TAG_W-1:0]              tag_ram [TAG_NUM];
    logic [TAG_NUM-1:0]            tag_valid;

    cache_geom_pkg::blk_addr_t     blk;
    logic [TAG_ADDR_W-1:0]         idx;
    logic [TAG_W-1:0]              tag;
    logic                          lookup;
    logic                          hit;
    logic                          take;

    // ----------------------------------------------------------------------
    // address split and tag compare
    // ----------------------------------------------------------------------

    assign blk = '{y: s_araddr.y[HI:LO], x: s_araddr.x[HI:LO]};
    assign idx = {blk.y[HALF_W-1:0], blk.x[HALF_W-1:0]};
    assign tag = {blk.y[BLK_W-1:HALF_W], blk.x[BLK_W-1:HALF_W]};

    assign lookup = (state == cache_ctrl_pkg::LOOKUP);
    assign hit    = tag_valid[idx] && (tag_ram[idx] == tag);

    // a miss needs room on both sides
    assign s_arready   = lookup && req_ready && (hit || fetch_ready);
    assign take        = s_arvalid && s_arready;
    assign clear_busy  = !lookup;

    assign req         = '{blk: blk, ofs: {s_araddr.y[LO-1:0], s_araddr.x[LO-1:0]}, miss: !hit};
    assign req_valid   = s_arvalid && lookup && (hit || fetch_ready);
    assign fetch       = '{y: {blk.y, {LO{1'b0}}}, x: {blk.x, {LO{1'b0}}}};
    assign fetch_valid = s_arvalid && lookup && !hit && req_ready;

    // ----------------------------------------------------------------------
    // valid bits, clear sweep, status
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= cache_ctrl_pkg::LOOKUP;
            clear_idx   <= '0;
            tag_valid   <= '0;
            status_hit  <= 1'b0;
            status_miss <= 1'b0;
        end else begin
            status_hit  <= take && hit;
            status_miss <= take && !hit;
            case (state)
                cache_ctrl_pkg::LOOKUP: begin
                    if (take && !hit) begin
                        tag_valid[idx] <= 1'b1;
                    end
                    if (clear_start) begin
                        state     <= cache_ctrl_pkg::CLEARING;
                        clear_idx <= '0;
                    end
                end
                cache_ctrl_pkg::CLEARING: begin
                    tag_valid[clear_idx] <= 1'b0;
                    clear_idx            <= clear_idx + 1'b1;
                    if (clear_idx == TAG_ADDR_W'(TAG_NUM - 1)) begin
                        state <= cache_ctrl_pkg::LOOKUP;
                    end
                end
                default: state <= cache_ctrl_pkg::LOOKUP;
            endcase
        end
    end

    // new tag goes in as soon as the miss is taken
    always_ff @(posedge clk) begin
        if (take && !hit) begin
            tag_ram[idx] <= tag;
        end
    end

    // nothing gets in for the whole sweep
    clear_blocks_requests: assert property (@(posedge clk) disable iff (reset)
        (lookup && clear_start) |=>
            (!take && state == cache_ctrl_pkg::CLEARING)[*TAG_NUM]);

endmodule

/* verilog/fetch_execute.sv */
module fetch_execute #(
    parameter int LOOKAHEAD_NUM = 2
) (
    input  logic                             clk,
    input  logic                             reset,
    input  cache_geom_pkg::fetch_t           fetch,
    input  logic                             fetch_valid,
    output logic                             fetch_ready,
    output cache_geom_pkg::coord_t           m_araddr,
    output logic                             m_arvalid,
    input  logic                             m_arready,
    input  logic [cache_geom_pkg::PIX_W-1:0] m_rdata,
    input  logic                             m_rvalid,
    input  logic                             line_done,
    output logic [cache_geom_pkg::PIX_W-1:0] buf_data,
    output logic                             buf_valid,
    input  logic                             buf_pop
);

    localparam int AF_PTR_W = (LOOKAHEAD_NUM > 1) ? $clog2(LOOKAHEAD_NUM) : 1;
    localparam int CNT_W    = $clog2(LOOKAHEAD_NUM + 1);
    localparam int RB_DEPTH = LOOKAHEAD_NUM * cache_geom_pkg::BLK_PIX;
    localparam int RB_PTR_W = $clog2(RB_DEPTH);
    localparam int RB_CNT_W = $clog2(RB_DEPTH + 1);

    cache_geom_pkg::fetch_t           af_mem [LOOKAHEAD_NUM];
    logic [AF_PTR_W-1:0]              af_wr;
    logic [AF_PTR_W-1:0]              af_rd;
    logic [CNT_W-1:0]                 af_count;
    logic                             af_push;
    logic                             af_pop;
    logic [CNT_W-1:0]                 outstanding;

    logic [cache_geom_pkg::PIX_W-1:0] rb_mem [RB_DEPTH];
    logic [RB_PTR_W-1:0]              rb_wr;
    logic [RB_PTR_W-1:0]              rb_rd;
    logic [RB_CNT_W-1:0]              rb_count;

    // ----------------------------------------------------------------------
    // miss address FIFO and limiter
    // ----------------------------------------------------------------------

    assign fetch_ready = (af_count != CNT_W'(LOOKAHEAD_NUM));
    assign af_push     = fetch_valid && fetch_ready;

    // blocks requested but not yet written into a line
    assign m_arvalid   = (af_count != '0) && (outstanding != CNT_W'(LOOKAHEAD_NUM));
    assign m_araddr    = af_mem[af_rd];
    assign af_pop      = m_arvalid && m_arready;

    always_ff @(posedge clk) begin
        if (reset) begin
            af_wr       <= '0;
            af_rd       <= '0;
            af_count    <= '0;
            outstanding <= '0;
        end else begin
            if (af_push) begin
                af_wr <= (af_wr == AF_PTR_W'(LOOKAHEAD_NUM - 1)) ? '0 : af_wr + 1'b1;
            end
            if (af_pop) begin
                af_rd <= (af_rd == AF_PTR_W'(LOOKAHEAD_NUM - 1)) ? '0 : af_rd + 1'b1;
            end
            if (af_push && !af_pop) begin
                af_count <= af_count + 1'b1;
            end else if (!af_push && af_pop) begin
                af_count <= af_count - 1'b1;
            end
            if (af_pop && !line_done) begin
                outstanding <= outstanding + 1'b1;
            end else if (!af_pop && line_done) begin
                outstanding <= outstanding - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (af_push) begin
            af_mem[af_wr] <= fetch;
        end
    end

    // ----------------------------------------------------------------------
    // read-data buffer
    // ----------------------------------------------------------------------

    assign buf_valid = (rb_count != '0);
    assign buf_data  = rb_mem[rb_rd];

    always_ff @(posedge clk) begin
        if (reset) begin
            rb_wr    <= '0;
            rb_rd    <= '0;
            rb_count <= '0;
        end else begin
            if (m_rvalid) begin
                rb_wr <= (rb_wr == RB_PTR_W'(RB_DEPTH - 1)) ? '0 : rb_wr + 1'b1;
            end
            if (buf_pop) begin
                rb_rd <= (rb_rd == RB_PTR_W'(RB_DEPTH - 1)) ? '0 : rb_rd + 1'b1;
            end
            if (m_rvalid && !buf_pop) begin
                rb_count <= rb_count + 1'b1;
            end else if (!m_rvalid && buf_pop) begin
                rb_count <= rb_count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (m_rvalid) begin
            rb_mem[rb_wr] <= m_rdata;
        end
    end

    // limiter and line_done from the result side keep room for every beat
    buffer_no_overflow: assert property (@(posedge clk) disable iff (reset)
        m_rvalid |-> (rb_count != RB_CNT_W'(RB_DEPTH)));

endmodule

/* verilog/pixel_result.sv */
module pixel_result #(
    parameter int TAG_ADDR_W = 4
) (
    input  logic                             clk,
    input  logic                             reset,
    input  cache_geom_pkg::pix_req_t         req,
    input  logic                             req_valid,
    output logic                             req_ready,
    input  logic [cache_geom_pkg::PIX_W-1:0] buf_data,
    input  logic                             buf_valid,
    output logic                             buf_pop,
    output logic                             line_done,
    output logic [cache_geom_pkg::PIX_W-1:0] s_rdata,
    output logic                             s_rvalid
);

    localparam int QUE_DEPTH = 4;
    localparam int QUE_PTR_W = $clog2(QUE_DEPTH);
    localparam int QUE_CNT_W = $clog2(QUE_DEPTH + 1);
    localparam int HALF_W    = TAG_ADDR_W / 2;
    localparam int OFS_W     = cache_geom_pkg::OFS_W;
    localparam int MEM_DEPTH = (1 << TAG_ADDR_W) * cache_geom_pkg::BLK_PIX;

    cache_ctrl_pkg::result_state_e    state;
    cache_geom_pkg::pix_req_t         que_mem [QUE_DEPTH];
    logic [QUE_PTR_W-1:0]             que_wr;
    logic [QUE_PTR_W-1:0]             que_rd;
    logic [QUE_CNT_W-1:0]             que_count;
    logic                             que_push;
    logic                             que_pop;
    cache_geom_pkg::pix_req_t         head;
    logic [TAG_ADDR_W-1:0]            head_idx;
    logic [OFS_W-1:0]                 fill_cnt;
    logic                             fill_beat;
    logic [cache_geom_pkg::PIX_W-1:0] data_mem [MEM_DEPTH];

    // ----------------------------------------------------------------------
    // in-order request queue
    // ----------------------------------------------------------------------

    assign req_ready = (que_count != QUE_CNT_W'(QUE_DEPTH));
    assign que_push  = req_valid && req_ready;
    assign que_pop   = s_rvalid;

    assign head      = que_mem[que_rd];
    assign head_idx  = {head.blk.y[HALF_W-1:0], head.blk.x[HALF_W-1:0]};

    always_ff @(posedge clk) begin
        if (reset) begin
            que_wr    <= '0;
            que_rd    <= '0;
            que_count <= '0;
        end else begin
            if (que_push) begin
                que_wr <= que_wr + 1'b1;
            end
            if (que_pop) begin
                que_rd <= que_rd + 1'b1;
            end
            if (que_push && !que_pop) begin
                que_count <= que_count + 1'b1;
            end else if (!que_push && que_pop) begin
                que_count <= que_count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (que_push) begin
            que_mem[que_wr] <= req;
        end
    end

    // ----------------------------------------------------------------------
    // refill and response
    // ----------------------------------------------------------------------

    assign fill_beat = (state == cache_ctrl_pkg::FILL) && buf_valid;
    assign buf_pop   = fill_beat;
    assign line_done = fill_beat && (fill_cnt == OFS_W'(cache_geom_pkg::BLK_PIX - 1));

    assign s_rvalid  = (state == cache_ctrl_pkg::RESPOND);
    assign s_rdata   = data_mem[{head_idx, head.ofs}];

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= cache_ctrl_pkg::HEAD;
            fill_cnt <= '0;
        end else begin
            case (state)
                cache_ctrl_pkg::HEAD: begin
                    fill_cnt <= '0;
                    if (que_count != '0) begin
                        if (head.miss) begin
                            state <= cache_ctrl_pkg::FILL;
                        end else begin
                            state <= cache_ctrl_pkg::RESPOND;
                        end
                    end
                end
                cache_ctrl_pkg::FILL: begin
                    // stalls while the buffer is empty
                    if (fill_beat) begin
                        fill_cnt <= fill_cnt + 1'b1;
                    end
                    if (line_done) begin
                        state <= cache_ctrl_pkg::RESPOND;
                    end
                end
                default: state <= cache_ctrl_pkg::HEAD;
            endcase
        end
    end

    // beats arrive in raster order, same as the offset
    always_ff @(posedge clk) begin
        if (fill_beat) begin
            data_mem[{head_idx, fill_cnt}] <= buf_data;
        end
    end

    // no result during a refill, and the refill serves a queued miss
    fill_holds_miss_head: assert property (@(posedge clk) disable iff (reset)
        (state == cache_ctrl_pkg::FILL) |-> (!s_rvalid && head.miss && que_count != '0));

endmodule

/* verilog/texture_cache_lookahead.sv */
module texture_cache_lookahead #(
    parameter int TAG_ADDR_W    = 4,
    parameter int LOOKAHEAD_NUM = 2
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             clear_start,
    output logic                             clear_busy,
    output logic                             status_hit,
    output logic                             status_miss,
    input  cache_geom_pkg::coord_t           s_araddr,
    input  logic                             s_arvalid,
    output logic                             s_arready,
    output logic [cache_geom_pkg::PIX_W-1:0] s_rdata,
    output logic                             s_rvalid,
    output cache_geom_pkg::coord_t           m_araddr,
    output logic                             m_arvalid,
    input  logic                             m_arready,
    input  logic [cache_geom_pkg::PIX_W-1:0] m_rdata,
    input  logic                             m_rvalid,
    input  logic                             m_rlast
);

    cache_geom_pkg::pix_req_t         req;
    logic                             req_valid;
    logic                             req_ready;
    cache_geom_pkg::fetch_t           fetch;
    logic                             fetch_valid;
    logic                             fetch_ready;
    logic [cache_geom_pkg::PIX_W-1:0] buf_data;
    logic                             buf_valid;
    logic                             buf_pop;
    logic                             line_done;

    // ----------------------------------------------------------------------
    // lookup, fetch, return
    // ----------------------------------------------------------------------

    tag_decode #(.TAG_ADDR_W(TAG_ADDR_W)) i_tag_decode (
        .clk, .reset, .clear_start, .clear_busy,
        .s_araddr, .s_arvalid, .s_arready,
        .status_hit, .status_miss,
        .req, .req_valid, .req_ready,
        .fetch, .fetch_valid, .fetch_ready
    );

    fetch_execute #(.LOOKAHEAD_NUM(LOOKAHEAD_NUM)) i_fetch_execute (
        .clk, .reset,
        .fetch, .fetch_valid, .fetch_ready,
        .m_araddr, .m_arvalid, .m_arready,
        .m_rdata, .m_rvalid, .line_done,
        .buf_data, .buf_valid, .buf_pop
    );

    pixel_result #(.TAG_ADDR_W(TAG_ADDR_W)) i_pixel_result (
        .clk, .reset,
        .req, .req_valid, .req_ready,
        .buf_data, .buf_valid, .buf_pop, .line_done,
        .s_rdata, .s_rvalid
    );

endmodule

/* bench/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // released on a rising edge, so the DUT sees RESET_CYCLES edges of it
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* bench/tb_texture_cache.sv */
module tb_texture_cache;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TAG_ADDR_W    = 4;
    localparam int LOOKAHEAD_NUM = 2;
    localparam int SEED          = 99417;
    localparam int WAIT_LIMIT    = 2000;
    localparam int GOLD_ROWS     = 51;

    logic                             clk;
    logic                             reset;
    logic                             clear_start;
    logic                             clear_busy;
    logic                             status_hit;
    logic                             status_miss;
    cache_geom_pkg::coord_t           s_araddr;
    logic                             s_arvalid;
    logic                             s_arready;
    logic [cache_geom_pkg::PIX_W-1:0] s_rdata;
    logic                             s_rvalid;
    cache_geom_pkg::coord_t           m_araddr;
    logic                             m_arvalid;
    logic                             m_arready;
    logic [cache_geom_pkg::PIX_W-1:0] m_rdata;
    logic                             m_rvalid;
    logic                             m_rlast;

    // five hex fields per row: test, x, y, pixel, hit
    logic [7:0]                       gold [256];
    cache_geom_pkg::coord_t           fetch_log [64];
    int miss_rows [$];
    int n_req            = 0;
    int errors           = 0;
    int mon_errors       = 0;
    int res_idx          = 0;
    int stat_idx         = 0;
    int ar_count         = 0;
    int port_outstanding = 0;

    tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(8)) i_clock_gen (.clk, .reset);

    texture_cache_lookahead #(
        .TAG_ADDR_W(TAG_ADDR_W),
        .LOOKAHEAD_NUM(LOOKAHEAD_NUM)
    ) i_dut (.*);

    function automatic logic [7:0] gold_byte(input int row, input int field);
        return gold[8'(5 * row + field)];
    endfunction

    function automatic logic [7:0] pixel_rule(input int x, input int y);
        return 8'((x + 3 * y) % 256);
    endfunction

    // 4x4 block that the n-th expected miss has to fetch
    function automatic int miss_block_addr(input int n);
        int row;
        if (n >= miss_rows.size()) begin
            return -1;
        end
        row = miss_rows[n];
        return int'({gold_byte(row, 2) & 8'hfc, gold_byte(row, 1) & 8'hfc});
    endfunction

    task automatic check_value(input string name, input int got, input int exp,
                               inout int count);
        assert (got == exp) else begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            count++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("timeout: %s", what);
        $display("Simulation failed");
        $finish;
    endtask

    // ----------------------------------------------------------------------
    // memory model
    // ----------------------------------------------------------------------

    // one block at a time, in address order
    initial begin
        cache_geom_pkg::coord_t base;
        int gap;
        int beat;
        int mem_rd;
        bit active;
        void'($urandom(SEED));
        m_arready = 1'b0;
        m_rvalid  = 1'b0;
        m_rdata   = '0;
        m_rlast   = 1'b0;
        base      = '0;
        gap       = 0;
        beat      = 0;
        mem_rd    = 0;
        active    = 1'b0;
        forever begin
            @(posedge clk);
            m_arready <= ($urandom % 4) != 0;
            m_rvalid  <= 1'b0;
            m_rlast   <= 1'b0;
            if (!active) begin
                if (mem_rd < ar_count) begin
                    base   = fetch_log[6'(mem_rd)];
                    mem_rd++;
                    gap    = int'($urandom % 6);
                    beat   = 0;
                    active = 1'b1;
                end
            end else if (gap != 0) begin
                gap--;
            end else begin
                m_rvalid <= 1'b1;
                m_rdata  <= pixel_rule(int'(base.x) + beat % 4, int'(base.y) + beat / 4);
                m_rlast  <= (beat == 15);
                beat++;
                active = (beat != 16);
            end
        end
    end

    // ----------------------------------------------------------------------
    // port monitor, sampled on the falling edge
    // ----------------------------------------------------------------------

    always @(negedge clk) begin
        if (!reset) begin
            if (s_rvalid) begin
                assert (res_idx < stat_idx) else begin
                    $display("result arrived with no accepted request left to answer");
                    mon_errors++;
                end
                check_value("s_rdata", int'(s_rdata), int'(gold_byte(res_idx, 3)), mon_errors);
                res_idx++;
            end
            if (status_hit || status_miss) begin
                check_value("status_hit", int'(status_hit),
                            int'(gold_byte(stat_idx, 4) != 8'h00), mon_errors);
                check_value("status_miss", int'(status_miss),
                            int'(gold_byte(stat_idx, 4) == 8'h00), mon_errors);
                stat_idx++;
            end
            if (m_arvalid && m_arready) begin
                check_value("m_araddr", int'(m_araddr), miss_block_addr(ar_count), mon_errors);
                fetch_log[6'(ar_count)] = m_araddr;
                ar_count++;
                port_outstanding++;
            end
            if (m_rvalid && m_rlast) begin
                port_outstanding--;
            end
            assert (port_outstanding <= LOOKAHEAD_NUM) else begin
                $display("more than %0d memory reads outstanding", LOOKAHEAD_NUM);
                mon_errors++;
            end
        end
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------

    task automatic send_requests(input int first, input int last);
        int k;
        int waited;
        @(posedge clk);
        for (k = first; k < last; k++) begin
            s_araddr  <= '{y: gold_byte(k, 2), x: gold_byte(k, 1)};
            s_arvalid <= 1'b1;
            waited = 0;
            @(negedge clk);
            while (!s_arready) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    abort_run("a request was never accepted");
                end
                @(negedge clk);
            end
            @(posedge clk);
        end
        s_arvalid <= 1'b0;
    endtask

    task automatic run_clear();
        int busy;
        @(posedge clk);
        clear_start <= 1'b1;
        @(posedge clk);
        clear_start <= 1'b0;
        busy = 0;
        @(negedge clk);
        while (clear_busy) begin
            busy++;
            if (busy > WAIT_LIMIT) begin
                abort_run("clear_busy never went low");
            end
            @(negedge clk);
        end
        check_value("clear_busy cycles", busy, 1 << TAG_ADDR_W, errors);
    endtask

    initial begin
        int i;
        int last;
        int test_no;
        int misses;
        int err0;
        int ar0;
        int waited;
        int n_tests;
        s_araddr    = '0;
        s_arvalid   = 1'b0;
        clear_start = 1'b0;
        for (i = 0; i < 256; i++) begin
            gold[8'(i)] = '0;
        end
        $readmemh("bench/texture_golden.txt", gold);
        while (n_req < GOLD_ROWS && gold_byte(n_req, 0) != 8'h00) begin
            n_req++;
        end
        for (i = 0; i < n_req; i++) begin
            if (gold_byte(i, 4) == 8'h00) begin
                miss_rows.push_back(i);
            end
        end

        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("reset was never released");
            end
        end while (reset);

        // idle outputs right after reset
        check_value("s_rvalid", int'(s_rvalid), 0, errors);
        check_value("m_arvalid", int'(m_arvalid), 0, errors);
        check_value("clear_busy", int'(clear_busy), 0, errors);
        check_value("status_hit", int'(status_hit), 0, errors);
        check_value("status_miss", int'(status_miss), 0, errors);
        check_value("s_arready", int'(s_arready), 1, errors);
        $display("test 1: reset values, %0d errors", errors);
        n_tests = 1;

        i = 0;
        while (i < n_req) begin
            test_no = int'(gold_byte(i, 0));
            last    = i;
            misses  = 0;
            while (last < n_req && int'(gold_byte(last, 0)) == test_no) begin
                if (gold_byte(last, 4) == 8'h00) begin
                    misses++;
                end
                last++;
            end
            err0 = errors + mon_errors;
            ar0  = ar_count;
            if (test_no == 6) begin
                run_clear();
            end
            send_requests(i, last);
            waited = 0;
            while (res_idx < last) begin
                @(posedge clk);
                waited++;
                if (waited > WAIT_LIMIT) begin
                    abort_run("results of a test did not all arrive");
                end
            end
            // a hit must never reach memory
            check_value("m_araddr accepts", ar_count - ar0, misses, errors);
            check_value("status pulses", stat_idx, last, errors);
            $display("test %0d: %0d requests, %0d misses, %0d errors",
                     test_no, last - i, misses, errors + mon_errors - err0);
            n_tests++;
            i = last;
        end

        $display("%0d tests, %0d requests, %0d errors", n_tests, n_req, errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* bench/texture_golden.txt */
// test  x   y   pixel  hit    all hex, pixel = (x + 3*y) mod 256
// hit 1 = expected tag hit in a direct-mapped store of 16 lines
2  00  00  00  0
2  15  06  27  0
2  2a  33  c3  0
2  7f  41  42  0
3  03  03  0c  1
3  14  07  29  1
3  29  30  b9  1
3  7d  43  46  1
3  01  02  07  1
4  11  02  17  0
4  02  01  05  0
4  12  03  1b  0
4  13  00  13  1
4  01  11  34  0
4  10  01  13  0
4  00  12  36  0
4  16  05  25  1
5  40  40  00  0
5  45  04  51  0
5  09  0a  27  0
5  8c  1d  e3  0
5  0e  9b  df  0
5  c4  e8  7c  0
5  3b  27  b0  0
5  43  43  0c  1
6  42  41  05  0
6  41  42  07  1
6  3a  26  ac  0

/* all.f */
verilog/cache_geom_pkg.sv
verilog/cache_ctrl_pkg.sv
verilog/tag_decode.sv
verilog/fetch_execute.sv
verilog/pixel_result.sv
verilog/texture_cache_lookahead.sv
bench/tb_clock_gen.sv
bench/tb_texture_cache.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_texture_cache
FILELIST  = all.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
